/* source/arm_pipeline_macros.svh */
// ARM pipeline widths
`ifndef ARM_PIPELINE_MACROS_SVH
`define ARM_PIPELINE_MACROS_SVH

// Data path and instruction word
`define ARM_WORD_WIDTH 32

// Register file geometry
`define ARM_REG_COUNT 16
`define ARM_REG_IDX_WIDTH 4

// Byte step between instruction addresses
`define ARM_PC_STEP 4

// Operand 2 field in bits 11:0
`define ARM_SHIFT_FIELD_WIDTH 12

`endif

/* source/arm_pipeline_pkg.sv */
// ARM pipeline types
`include "arm_pipeline_macros.svh"

package arm_pipeline_pkg;

  typedef logic [`ARM_WORD_WIDTH-1:0] word_t;
  typedef logic [`ARM_REG_IDX_WIDTH-1:0] reg_idx_t;
  typedef logic [`ARM_SHIFT_FIELD_WIDTH-1:0] shift_field_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef enum logic [3:0] {
    alu_add     = 4'b0000,
    alu_adc     = 4'b0001,
    alu_sub     = 4'b0010,
    alu_sbc     = 4'b0011,
    alu_rsb     = 4'b0100,
    alu_rsc     = 4'b0101,
    alu_and     = 4'b0110,
    alu_or      = 4'b0111,
    alu_xor     = 4'b1000,
    alu_pass_a  = 4'b1001,
    alu_pass_b  = 4'b1010,
    alu_not_b   = 4'b1011,
    alu_and_not = 4'b1100
  } alu_op_e;

  // Instruction bits 24:21
  typedef enum logic [3:0] {
    dp_and, dp_eor, dp_sub, dp_rsb, dp_add, dp_adc, dp_sbc, dp_rsc,
    dp_tst, dp_teq, dp_cmp, dp_cmn, dp_orr, dp_mov, dp_bic, dp_mvn
  } dp_opcode_e;

  typedef enum logic {shift_imm_rot, shift_reg} shift_mode_e;

  typedef enum logic [1:0] {shift_lsl, shift_lsr, shift_asr, shift_ror} shift_type_e;

  typedef enum logic [1:0] {fwd_rf, fwd_ex, fwd_wb} fwd_sel_e;

endpackage

/* source/decode_execute_if.sv */
// Decode to execute handoff
interface decode_execute_if;

  arm_pipeline_pkg::alu_op_e     alu_op;
  logic                          s_bit;
  logic                          rf_enable;
  arm_pipeline_pkg::shift_mode_e shift_mode;
  arm_pipeline_pkg::shift_field_t shift_field;
  arm_pipeline_pkg::word_t       operand_a;    // Rn after forwarding
  arm_pipeline_pkg::word_t       operand_m;    // Rm after forwarding
  arm_pipeline_pkg::reg_idx_t    rd;
  logic                          ex_rf_enable;
  arm_pipeline_pkg::reg_idx_t    ex_rd;
  arm_pipeline_pkg::word_t       ex_result;    // Combinational ALU output

  modport decode (
    output alu_op, s_bit, rf_enable, shift_mode, shift_field, operand_a, operand_m, rd,
    input  ex_rf_enable, ex_rd, ex_result
  );

  modport execute (
    input  alu_op, s_bit, rf_enable, shift_mode, shift_field, operand_a, operand_m, rd,
    output ex_rf_enable, ex_rd, ex_result
  );

endinterface

/* source/fetch_unit.sv */
// Program counter and fetch register
`include "arm_pipeline_macros.svh"

module fetch_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  arm_pipeline_pkg::word_t instr,
  output arm_pipeline_pkg::word_t pc,
  output arm_pipeline_pkg::word_t id_instr
);

  arm_pipeline_pkg::word_t next_pc;

  // No stall, so the PC advances every cycle
  assign next_pc = pc + arm_pipeline_pkg::word_t'(`ARM_PC_STEP);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc       <= '0;
      id_instr <= '0;            // Zero word decodes as NOP
    end else begin
      pc       <= next_pc;
      id_instr <= instr;         // Word at the current pc
    end
  end

endmodule

/* source/register_file.sv */
// Sixteen entry register file
`include "arm_pipeline_macros.svh"

module register_file (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       wb_enable,
  input  arm_pipeline_pkg::reg_idx_t wb_rd,
  input  arm_pipeline_pkg::word_t    wb_data,
  input  arm_pipeline_pkg::reg_idx_t rn_idx,
  input  arm_pipeline_pkg::reg_idx_t rm_idx,
  output arm_pipeline_pkg::word_t    rn_data,
  output arm_pipeline_pkg::word_t    rm_data
);

  arm_pipeline_pkg::word_t regs [`ARM_REG_COUNT];   // R15 is a plain register here

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `ARM_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_enable) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Same-cycle writes are covered by the write-back forward in decode
  assign rn_data = regs[rn_idx];
  assign rm_data = regs[rm_idx];

endmodule

/* source/decode_stage.sv */
// Instruction decode and forwarding
module decode_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  arm_pipeline_pkg::word_t    id_instr,
  input  logic                       wb_enable,
  input  arm_pipeline_pkg::reg_idx_t wb_rd,
  input  arm_pipeline_pkg::word_t    wb_data,
  output arm_pipeline_pkg::reg_idx_t rn_idx,
  output arm_pipeline_pkg::reg_idx_t rm_idx,
  input  arm_pipeline_pkg::word_t    rn_data,
  input  arm_pipeline_pkg::word_t    rm_data,
  decode_execute_if.decode           dx
);

  arm_pipeline_pkg::dp_opcode_e  opcode;
  arm_pipeline_pkg::alu_op_e     id_alu_op;
  arm_pipeline_pkg::shift_mode_e id_shift_mode;
  arm_pipeline_pkg::fwd_sel_e    rn_sel;
  arm_pipeline_pkg::fwd_sel_e    rm_sel;
  arm_pipeline_pkg::word_t       rn_value;
  arm_pipeline_pkg::word_t       rm_value;
  logic                          is_imm;
  logic                          is_reg_shift;
  logic                          is_compare;
  logic                          id_valid;

  assign rn_idx = id_instr[19:16];
  assign rm_idx = id_instr[3:0];
  assign opcode = arm_pipeline_pkg::dp_opcode_e'(id_instr[24:21]);

  // Class 001 rotated immediate, class 000 with bit 4 clear shifted register
  assign is_imm        = (id_instr[27:25] == 3'b001);
  assign is_reg_shift  = (id_instr[27:25] == 3'b000) && !id_instr[4] && (id_instr != '0);
  assign id_valid      = is_imm || is_reg_shift;
  assign id_shift_mode = is_imm ? arm_pipeline_pkg::shift_imm_rot : arm_pipeline_pkg::shift_reg;
  assign is_compare    = opcode inside {arm_pipeline_pkg::dp_tst, arm_pipeline_pkg::dp_teq,
                                        arm_pipeline_pkg::dp_cmp, arm_pipeline_pkg::dp_cmn};

  always_comb begin
    case (opcode)
      arm_pipeline_pkg::dp_and: id_alu_op = arm_pipeline_pkg::alu_and;
      arm_pipeline_pkg::dp_eor: id_alu_op = arm_pipeline_pkg::alu_xor;
      arm_pipeline_pkg::dp_sub: id_alu_op = arm_pipeline_pkg::alu_sub;
      arm_pipeline_pkg::dp_rsb: id_alu_op = arm_pipeline_pkg::alu_rsb;
      arm_pipeline_pkg::dp_add: id_alu_op = arm_pipeline_pkg::alu_add;
      arm_pipeline_pkg::dp_adc: id_alu_op = arm_pipeline_pkg::alu_adc;
      arm_pipeline_pkg::dp_sbc: id_alu_op = arm_pipeline_pkg::alu_sbc;
      arm_pipeline_pkg::dp_rsc: id_alu_op = arm_pipeline_pkg::alu_rsc;
      arm_pipeline_pkg::dp_tst: id_alu_op = arm_pipeline_pkg::alu_and;
      arm_pipeline_pkg::dp_teq: id_alu_op = arm_pipeline_pkg::alu_xor;
      arm_pipeline_pkg::dp_cmp: id_alu_op = arm_pipeline_pkg::alu_sub;
      arm_pipeline_pkg::dp_cmn: id_alu_op = arm_pipeline_pkg::alu_add;
      arm_pipeline_pkg::dp_orr: id_alu_op = arm_pipeline_pkg::alu_or;
      arm_pipeline_pkg::dp_mov: id_alu_op = arm_pipeline_pkg::alu_pass_b;
      arm_pipeline_pkg::dp_bic: id_alu_op = arm_pipeline_pkg::alu_and_not;
      default:                  id_alu_op = arm_pipeline_pkg::alu_not_b;   // MVN
    endcase
  end

  // Youngest producer wins
  assign rn_sel = (dx.ex_rf_enable && (rn_idx == dx.ex_rd)) ? arm_pipeline_pkg::fwd_ex :
                  (wb_enable && (rn_idx == wb_rd))          ? arm_pipeline_pkg::fwd_wb :
                                                              arm_pipeline_pkg::fwd_rf;
  assign rm_sel = (dx.ex_rf_enable && (rm_idx == dx.ex_rd)) ? arm_pipeline_pkg::fwd_ex :
                  (wb_enable && (rm_idx == wb_rd))          ? arm_pipeline_pkg::fwd_wb :
                                                              arm_pipeline_pkg::fwd_rf;

  always_comb begin
    case (rn_sel)
      arm_pipeline_pkg::fwd_ex: rn_value = dx.ex_result;
      arm_pipeline_pkg::fwd_wb: rn_value = wb_data;
      default:                  rn_value = rn_data;
    endcase
    case (rm_sel)
      arm_pipeline_pkg::fwd_ex: rm_value = dx.ex_result;
      arm_pipeline_pkg::fwd_wb: rm_value = wb_data;
      default:                  rm_value = rm_data;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dx.rf_enable <= 1'b0;
      dx.s_bit     <= 1'b0;
    end else begin
      dx.rf_enable <= id_valid && !is_compare;   // Compares only touch flags
      dx.s_bit     <= id_valid && id_instr[20];
    end
  end

  always_ff @(posedge clk) begin
    dx.alu_op      <= id_alu_op;
    dx.shift_mode  <= id_shift_mode;
    dx.shift_field <= id_instr[11:0];
    dx.operand_a   <= rn_value;
    dx.operand_m   <= rm_value;
    dx.rd          <= id_instr[15:12];
  end

endmodule

/* source/operand_shifter.sv */
// Operand 2 rotate and shift
module operand_shifter (
  input  arm_pipeline_pkg::shift_mode_e  shift_mode,
  input  arm_pipeline_pkg::shift_field_t shift_field,
  input  arm_pipeline_pkg::word_t        operand_m,
  output arm_pipeline_pkg::word_t        operand_b
);

  function automatic arm_pipeline_pkg::word_t rotate_right(arm_pipeline_pkg::word_t value,
                                                           logic [4:0] amount);
    // Left shift by the full width clears, so amount 0 returns value
    return (value >> amount) | (value << (6'd32 - {1'b0, amount}));
  endfunction

  arm_pipeline_pkg::shift_type_e shift_type;
  arm_pipeline_pkg::word_t       imm_value;
  logic [4:0]                    rot_amt;
  logic [4:0]                    shift_amt;

  assign shift_type = arm_pipeline_pkg::shift_type_e'(shift_field[6:5]);
  assign imm_value  = {24'b0, shift_field[7:0]};
  assign rot_amt    = {shift_field[11:8], 1'b0};    // Twice the 4-bit rotate
  assign shift_amt  = shift_field[11:7];

  always_comb begin
    if (shift_mode == arm_pipeline_pkg::shift_imm_rot) begin
      operand_b = rotate_right(imm_value, rot_amt);
    end else begin
      case (shift_type)
        arm_pipeline_pkg::shift_lsl: operand_b = operand_m << shift_amt;
        arm_pipeline_pkg::shift_lsr: operand_b = operand_m >> shift_amt;
        arm_pipeline_pkg::shift_asr: operand_b = $signed(operand_m) >>> shift_amt;
        default:                     operand_b = rotate_right(operand_m, shift_amt);
      endcase
    end
  end

endmodule

/* source/alu.sv */
// ALU with NZCV generation
`include "arm_pipeline_macros.svh"

module alu (
  input  arm_pipeline_pkg::alu_op_e alu_op,
  input  arm_pipeline_pkg::word_t   a,
  input  arm_pipeline_pkg::word_t   b,
  input  logic                      carry_in,
  output arm_pipeline_pkg::word_t   result,
  output arm_pipeline_pkg::flags_t  result_flags
);

  localparam int msb = `ARM_WORD_WIDTH - 1;

  logic                    reverse;
  logic                    add_cin;
  logic                    sub_cin;
  logic [`ARM_WORD_WIDTH:0] sum;
  arm_pipeline_pkg::word_t minuend;
  arm_pipeline_pkg::word_t subtrahend;
  arm_pipeline_pkg::word_t difference;
  logic                    borrow;
  logic                    add_ovf;
  logic                    sub_ovf;

  // One adder and one subtractor shared by all arithmetic ops
  assign reverse    = alu_op inside {arm_pipeline_pkg::alu_rsb, arm_pipeline_pkg::alu_rsc};
  assign minuend    = reverse ? b : a;
  assign subtrahend = reverse ? a : b;
  assign add_cin    = (alu_op == arm_pipeline_pkg::alu_adc) && carry_in;
  assign sub_cin    = (alu_op inside {arm_pipeline_pkg::alu_sbc, arm_pipeline_pkg::alu_rsc})
                      && carry_in;

  assign sum        = {1'b0, a} + {1'b0, b} + {{`ARM_WORD_WIDTH{1'b0}}, add_cin};
  assign difference = minuend - subtrahend - {{msb{1'b0}}, sub_cin};
  assign borrow     = {1'b0, minuend} < ({1'b0, subtrahend} + {{`ARM_WORD_WIDTH{1'b0}}, sub_cin});

  assign add_ovf = ~(a[msb] ^ b[msb]) & (a[msb] ^ sum[msb]);
  assign sub_ovf = (minuend[msb] ^ subtrahend[msb]) & (minuend[msb] ^ difference[msb]);

  always_comb begin
    result         = '0;
    result_flags.c = carry_in;   // Logical ops keep the stored carry
    result_flags.v = 1'b0;       // Execute stage keeps the stored V instead
    case (alu_op)
      arm_pipeline_pkg::alu_add, arm_pipeline_pkg::alu_adc: begin
        result         = sum[msb:0];
        result_flags.c = sum[`ARM_WORD_WIDTH];
        result_flags.v = add_ovf;
      end
      arm_pipeline_pkg::alu_sub, arm_pipeline_pkg::alu_sbc,
      arm_pipeline_pkg::alu_rsb, arm_pipeline_pkg::alu_rsc: begin
        result         = difference;
        result_flags.c = borrow;   // Set on borrow
        result_flags.v = sub_ovf;
      end
      arm_pipeline_pkg::alu_and:     result = a & b;
      arm_pipeline_pkg::alu_or:      result = a | b;
      arm_pipeline_pkg::alu_xor:     result = a ^ b;
      arm_pipeline_pkg::alu_pass_a:  result = a;
      arm_pipeline_pkg::alu_pass_b:  result = b;
      arm_pipeline_pkg::alu_not_b:   result = ~b;
      arm_pipeline_pkg::alu_and_not: result = a & ~b;
      default:                       result = '0;
    endcase
    result_flags.n = result[msb];
    result_flags.z = (result == '0);
  end

endmodule

/* source/execute_stage.sv */
// Execute stage and write-back register
module execute_stage (
  input  logic                       clk,
  input  logic                       reset,
  decode_execute_if.execute          dx,
  output logic                       wb_enable,
  output arm_pipeline_pkg::reg_idx_t wb_rd,
  output arm_pipeline_pkg::word_t    wb_data,
  output arm_pipeline_pkg::flags_t   flags
);

  arm_pipeline_pkg::word_t  operand_b;
  arm_pipeline_pkg::word_t  alu_result;
  arm_pipeline_pkg::flags_t result_flags;
  arm_pipeline_pkg::flags_t next_flags;
  logic                     arith_op;

  operand_shifter u_shifter (
    .shift_mode  (dx.shift_mode),
    .shift_field (dx.shift_field),
    .operand_m   (dx.operand_m),
    .operand_b   (operand_b)
  );

  alu u_alu (
    .alu_op       (dx.alu_op),
    .a            (dx.operand_a),
    .b            (operand_b),
    .carry_in     (flags.c),        // Stored carry into ADC, SBC, RSC
    .result       (alu_result),
    .result_flags (result_flags)
  );

  // Back to decode for the distance-1 forward
  assign dx.ex_result    = alu_result;
  assign dx.ex_rd        = dx.rd;
  assign dx.ex_rf_enable = dx.rf_enable;

  assign arith_op = dx.alu_op inside {[arm_pipeline_pkg::alu_add : arm_pipeline_pkg::alu_rsc]};

  always_comb begin
    next_flags = result_flags;
    if (!arith_op) begin
      next_flags.v = flags.v;      // Logical ops leave V alone
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags     <= '0;
      wb_enable <= 1'b0;
    end else begin
      wb_enable <= dx.rf_enable;
      if (dx.s_bit) begin
        flags <= next_flags;
      end
    end
  end

  always_ff @(posedge clk) begin
    wb_rd   <= dx.rd;
    wb_data <= alu_result;
  end

endmodule

/* source/arm_pipeline_top.sv */
// ARM data-processing pipeline top
module arm_pipeline_top (
  input  logic                       clk,
  input  logic                       reset,
  input  arm_pipeline_pkg::word_t    instr,
  output arm_pipeline_pkg::word_t    pc,
  output logic                       wb_enable,
  output arm_pipeline_pkg::reg_idx_t wb_rd,
  output arm_pipeline_pkg::word_t    wb_data,
  output arm_pipeline_pkg::flags_t   flags
);

  arm_pipeline_pkg::word_t    id_instr;
  arm_pipeline_pkg::reg_idx_t rn_idx;
  arm_pipeline_pkg::reg_idx_t rm_idx;
  arm_pipeline_pkg::word_t    rn_data;
  arm_pipeline_pkg::word_t    rm_data;

  decode_execute_if dx_if ();

  fetch_unit u_fetch (
    .clk      (clk),
    .reset    (reset),
    .instr    (instr),
    .pc       (pc),
    .id_instr (id_instr)
  );

  register_file u_regs (
    .clk       (clk),
    .reset     (reset),
    .wb_enable (wb_enable),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .rn_idx    (rn_idx),
    .rm_idx    (rm_idx),
    .rn_data   (rn_data),
    .rm_data   (rm_data)
  );

  decode_stage u_decode (
    .clk       (clk),
    .reset     (reset),
    .id_instr  (id_instr),
    .wb_enable (wb_enable),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .rn_idx    (rn_idx),
    .rm_idx    (rm_idx),
    .rn_data   (rn_data),
    .rm_data   (rm_data),
    .dx        (dx_if.decode)
  );

  execute_stage u_execute (
    .clk       (clk),
    .reset     (reset),
    .dx        (dx_if.execute),
    .wb_enable (wb_enable),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .flags     (flags)
  );

endmodule

/* verification/arm_pipeline_properties.sv */
// Pipeline port assertions
module arm_pipeline_properties (
  input logic                    clk,
  input logic                    reset,
  input arm_pipeline_pkg::word_t pc,
  input logic                    wb_enable,
  input arm_pipeline_pkg::word_t wb_data
);
  timeunit 1ns;
  timeprecision 1ps;

  // No write-back while held in reset
  reset_quiet: assert property (@(posedge clk) reset |-> !wb_enable)
    else $error("wb_enable high during reset");

  pc_step: assert property (@(posedge clk) disable iff (reset)
                            !$past(reset) |-> (pc == $past(pc) + 32'd4))
    else $error("pc did not step by 4");

  wb_data_known: assert property (@(posedge clk) disable iff (reset)
                                  wb_enable |-> !$isunknown(wb_data))
    else $error("wb_data has unknown bits on a write-back");

endmodule

bind arm_pipeline_top arm_pipeline_properties u_props (
  .clk       (clk),
  .reset     (reset),
  .pc        (pc),
  .wb_enable (wb_enable),
  .wb_data   (wb_data)
);

/* verification/arm_pipeline_tb.sv */
// ARM pipeline testbench
module arm_pipeline_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct {
    string                      name;
    arm_pipeline_pkg::word_t    instr;
    logic                       wb_enable;
    arm_pipeline_pkg::reg_idx_t wb_rd;
    arm_pipeline_pkg::word_t    wb_data;
    arm_pipeline_pkg::flags_t   flags;
  } test_entry_t;

  logic                       clk;
  logic                       reset;
  arm_pipeline_pkg::word_t    instr;
  arm_pipeline_pkg::word_t    pc;
  logic                       wb_enable;
  arm_pipeline_pkg::reg_idx_t wb_rd;
  arm_pipeline_pkg::word_t    wb_data;
  arm_pipeline_pkg::flags_t   flags;

  test_entry_t table_q[$];
  int          errors;
  int          passed;
  int          failed;
  logic        timed_out;

  arm_pipeline_top uut (
    .clk(clk), .reset(reset), .instr(instr), .pc(pc),
    .wb_enable(wb_enable), .wb_rd(wb_rd), .wb_data(wb_data), .flags(flags)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Instruction memory, word at pc/4
  always @(negedge clk) begin
    if ((pc >> 2) < table_q.size()) instr <= table_q[pc >> 2].instr;
    else instr <= '0;
  end

  task automatic add_test(string name, arm_pipeline_pkg::word_t word, logic en,
                          arm_pipeline_pkg::reg_idx_t rd, arm_pipeline_pkg::word_t data,
                          logic [3:0] nzcv);
    test_entry_t e;
    e.name = name;
    e.instr = word;
    e.wb_enable = en;
    e.wb_rd = rd;
    e.wb_data = data;
    e.flags = arm_pipeline_pkg::flags_t'(nzcv);
    table_q.push_back(e);
  endtask

  task automatic check_word(string name, string what, arm_pipeline_pkg::word_t exp,
                            arm_pipeline_pkg::word_t act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %h actual %h", name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_reg(string name, arm_pipeline_pkg::reg_idx_t exp,
                           arm_pipeline_pkg::reg_idx_t act);
    if (act !== exp) begin
      $display("ERROR %s: wb_rd expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flags(string name, arm_pipeline_pkg::flags_t exp,
                             arm_pipeline_pkg::flags_t act);
    if (act !== exp) begin
      $display("ERROR %s: flags expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  // Falling edges until pc matches
  task automatic wait_for_pc(arm_pipeline_pkg::word_t target, output logic ok);
    int cycles;
    cycles = 0;
    ok = 1'b0;
    while (!ok && cycles < 50) begin
      @(negedge clk);
      ok = (pc == target);
      cycles++;
    end
  endtask

  task automatic finish_test(string name, int errors_before);
    if (errors == errors_before) begin
      $display("PASS %s", name);
      passed++;
    end else begin
      $display("FAIL %s", name);
      failed++;
    end
  endtask

  initial begin
    int   start_errors;
    logic ok;
    reset = 1'b1;
    instr = '0;
    errors = 0;
    passed = 0;
    failed = 0;
    timed_out = 1'b0;
    add_test("mov_imm",       32'hE3A01012, 1, 4'd1,  32'h00000012, 4'b0000);
    add_test("mov_rot8",      32'hE3A024FF, 1, 4'd2,  32'hFF000000, 4'b0000);
    add_test("mvn_rot2",      32'hE3E0313F, 1, 4'd3,  32'h3FFFFFF0, 4'b0000);
    add_test("mov_rot30",     32'hE3A04FAB, 1, 4'd4,  32'h000002AC, 4'b0000);
    add_test("mov_r6",        32'hE3A06005, 1, 4'd6,  32'h00000005, 4'b0000);
    add_test("fwd_ex",        32'hE2867003, 1, 4'd7,  32'h00000008, 4'b0000);
    add_test("fwd_ex_wb",     32'hE0868007, 1, 4'd8,  32'h0000000D, 4'b0000);
    add_test("fwd_rf_wb",     32'hE0869007, 1, 4'd9,  32'h0000000D, 4'b0000);
    add_test("adds_carry",    32'hE092A002, 1, 4'd10, 32'hFE000000, 4'b1010);
    add_test("adcs_cin",      32'hE0B1B001, 1, 4'd11, 32'h00000025, 4'b0000);
    add_test("subs_zero",     32'hE051C001, 1, 4'd12, 32'h00000000, 4'b0100);
    add_test("subs_borrow",   32'hE051D004, 1, 4'd13, 32'hFFFFFD66, 4'b1010);
    add_test("sbcs_cin",      32'hE0D4E001, 1, 4'd14, 32'h00000299, 4'b0000);
    add_test("rsbs_imm",      32'hE2710010, 1, 4'd0,  32'hFFFFFFFE, 4'b1010);
    add_test("mov_7f",        32'hE3A0547F, 1, 4'd5,  32'h7F000000, 4'b1010);
    add_test("adds_ovf",      32'hE0955005, 1, 4'd5,  32'hFE000000, 4'b1001);
    add_test("sbcs_no_cin",   32'hE2D56002, 1, 4'd6,  32'hFDFFFFFE, 4'b1000);
    add_test("mov_min",       32'hE3A09102, 1, 4'd9,  32'h80000000, 4'b1000);
    add_test("subs_ovf",      32'hE0589009, 1, 4'd9,  32'h8000000D, 4'b1011);
    add_test("ands_lsl",      32'hE013A204, 1, 4'd10, 32'h00002AC0, 4'b0011);
    add_test("eors_lsr",      32'hE032B124, 1, 4'd11, 32'hFF0000AB, 4'b1011);
    add_test("orrs_asr",      32'hE191C242, 1, 4'd12, 32'hFFF00012, 4'b1011);
    add_test("bics_ror",      32'hE1D3D464, 1, 4'd13, 32'h13FFFFF0, 4'b0011);
    add_test("cmp_equal",     32'hE1510001, 0, 4'd0,  32'h00000000, 4'b0100);
    add_test("tst_neg",       32'hE1120002, 0, 4'd0,  32'h00000000, 4'b1000);
    add_test("nop_zero",      32'h00000000, 0, 4'd0,  32'h00000000, 4'b1000);
    add_test("nop_class010",  32'hE5912000, 0, 4'd0,  32'h00000000, 4'b1000);
    add_test("nop_reg_shift", 32'hE0912312, 0, 4'd0,  32'h00000000, 4'b1000);
    add_test("mov_last",      32'hE3A01001, 1, 4'd1,  32'h00000001, 4'b1000);

    // Reset state, then the first pc step
    start_errors = errors;
    repeat (16) begin
      @(negedge clk);
      check_word("reset", "pc", 32'h0, pc);
      check_word("reset", "wb_enable", 32'h0, {31'b0, wb_enable});
      check_flags("reset", '0, flags);
    end
    reset = 1'b0;
    wait_for_pc(32'h4, ok);
    if (!ok) begin
      $display("Timeout: pc never reached 4 after reset release");
      errors++;
      timed_out = 1'b1;
    end
    finish_test("reset", start_errors);

    // Entry i is in write-back while pc is 4*i + 12
    for (int i = 0; i < table_q.size() && !timed_out; i++) begin
      start_errors = errors;
      wait_for_pc(arm_pipeline_pkg::word_t'(4 * i + 12), ok);
      if (!ok) begin
        $display("Timeout: pc never reached the write-back slot of %s", table_q[i].name);
        errors++;
        timed_out = 1'b1;
      end else begin
        check_word(table_q[i].name, "wb_enable", {31'b0, table_q[i].wb_enable},
                   {31'b0, wb_enable});
        if (table_q[i].wb_enable) begin
          check_reg(table_q[i].name, table_q[i].wb_rd, wb_rd);
          check_word(table_q[i].name, "wb_data", table_q[i].wb_data, wb_data);
        end
        check_flags(table_q[i].name, table_q[i].flags, flags);
      end
      finish_test(table_q[i].name, start_errors);
    end

    $display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
    if (errors == 0 && failed == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+source
source/arm_pipeline_pkg.sv
source/decode_execute_if.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_stage.sv
source/operand_shifter.sv
source/alu.sv
source/execute_stage.sv
source/arm_pipeline_top.sv
verification/arm_pipeline_properties.sv
verification/arm_pipeline_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= arm_pipeline_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
